//--- tg_trace.txt
# S opens a session, W <addr> <data> is an expected write beat, C <addr> <xor mask> corrupts
# the stored word, E <pass> <error count> <first failing addr> runs it; all values in hex.
# clean run over the whole table.
S
W 0100 1D872B41  W 0101 8EE395A3  W 0102 C751CAD2  W 0103 63A8E569
W 0104 B1F472B7  W 0105 D8DA3958  W 0106 6C6D1CAC  W 0107 36368E56
W 0108 1B1B472B  W 0109 8DADA396  W 010A 46D6D1CB  W 010B A34B68E6
W 010C 51A5B473  W 010D A8F2DA3A  W 010E 54796D1D  W 010F AA1CB68D
E 1 0000 0000
# a single flipped bit in one beat.
S
W 0100 1D872B41  W 0101 8EE395A3  W 0102 C751CAD2  W 0103 63A8E569
W 0104 B1F472B7  W 0105 D8DA3958  W 0106 6C6D1CAC  W 0107 36368E56
W 0108 1B1B472B  W 0109 8DADA396  W 010A 46D6D1CB  W 010B A34B68E6
W 010C 51A5B473  W 010D A8F2DA3A  W 010E 54796D1D  W 010F AA1CB68D
C 0105 00000001
E 0 0001 0105
# two hits on one address, one outside the run.
S
W 0100 1D872B41  W 0101 8EE395A3  W 0102 C751CAD2  W 0103 63A8E569
W 0104 B1F472B7  W 0105 D8DA3958  W 0106 6C6D1CAC  W 0107 36368E56
W 0108 1B1B472B  W 0109 8DADA396  W 010A 46D6D1CB  W 010B A34B68E6
W 010C 51A5B473  W 010D A8F2DA3A  W 010E 54796D1D  W 010F AA1CB68D
C 010A FFFF0000  C 0103 00000080  C 010A 0000000F  C 0200 12345678
E 0 0002 0103

//--- vlog.f
+incdir+.
tg_pkg.sv
tg_pattern_gen.sv
tg_cfg_master.sv
tg_cfg_regs.sv
tg_traffic_engine.sv
tg_subsys_top.sv
tb_tg_subsys.sv

//--- Bender.yml
package:
  name: tg_subsys

sources:
  - include_dirs:
      - .
    files:
      - tg_pkg.sv
      - tg_pattern_gen.sv
      - tg_cfg_master.sv
      - tg_cfg_regs.sv
      - tg_traffic_engine.sv
      - tg_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tg_subsys.sv

//--- tb_tg_subsys.sv
/*
 * Testbench for the traffic generator subsystem.
 * Replays sessions from a trace file against a memory model with random
 * waitrequest stalls and injected corruption, then checks the run results.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tg_consts.svh"

module tb_tg_subsys import tg_pkg::*; ();

   localparam int DONE_TIMEOUT = 2000;   // cycles allowed from reset release to done.

   logic         clk;
   logic         reset;
   logic         mem_write;
   logic         mem_read;
   tg_mem_addr_t mem_address;
   tg_mem_data_t mem_writedata;
   logic         mem_waitrequest;
   tg_mem_data_t mem_readdata;
   logic         mem_readdatavalid;
   logic         done;
   logic         pass;
   logic         fail;
   logic [15:0]  error_count;
   tg_mem_addr_t first_fail_address;

   // ==============================
   // memory model and trace state
   // ==============================
   tg_mem_data_t mem [tg_mem_addr_t];
   tg_mem_data_t corrupt_mask [tg_mem_addr_t];   // xor applied when the word is stored.
   tg_mem_addr_t exp_addr [$];
   tg_mem_data_t exp_data [$];
   tg_mem_data_t ret_data [$];
   longint       ret_due [$];
   longint       cycle;
   logic [31:0]  rand_state;
   int           writes_seen;
   int           reads_issued;
   int           reads_returned;

   tg_subsys_top UUT (
      .clk                (clk),
      .reset              (reset),
      .mem_write          (mem_write),
      .mem_read           (mem_read),
      .mem_address        (mem_address),
      .mem_writedata      (mem_writedata),
      .mem_waitrequest    (mem_waitrequest),
      .mem_readdata       (mem_readdata),
      .mem_readdatavalid  (mem_readdatavalid),
      .done               (done),
      .pass               (pass),
      .fail               (fail),
      .error_count        (error_count),
      .first_fail_address (first_fail_address)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // value that the user table writes to a register. It is -1 if no row writes it.
   function automatic int configured_value(input logic [`TG_CFG_ADDR_WIDTH-1:0] reg_addr);
      int value;
      value = -1;
      for (int i = 0; i < TG_USER_CFG_N_ROW; i++) begin
         if (TG_USER_CFG_ROWS[i].addr == reg_addr) value = int'(TG_USER_CFG_ROWS[i].data);
      end
      return value;
   endfunction

   function automatic tg_mem_data_t fill_word(input tg_mem_addr_t addr);
      return {addr, ~addr};   // unwritten locations read back as this.
   endfunction

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_addr(input string name, input tg_mem_addr_t got,
                             input tg_mem_addr_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED: %s got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input tg_mem_data_t got,
                             input tg_mem_data_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED: %s got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED: %s got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED: %s got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic clear_model();
      mem.delete();
      ret_data.delete();
      ret_due.delete();
      writes_seen    = 0;
      reads_issued   = 0;
      reads_returned = 0;
   endtask

   // looks at the bus as the DUT saw it just before the rising edge.
   task automatic observe_bus();
      int           idx;
      tg_mem_data_t word;
      if (writes_seen == 0 && (mem_read || done || pass || fail)) begin
         stop_with_failure("a control output was high before the first write of the run");
      end
      if (mem_write && !mem_waitrequest) begin
         idx = writes_seen;
         if (idx >= exp_addr.size()) stop_with_failure("more writes than the configured beats");
         check_addr("mem_address", mem_address, exp_addr[idx]);
         check_data("mem_writedata", mem_writedata, exp_data[idx]);
         word = mem_writedata;
         if (corrupt_mask.exists(mem_address)) word = word ^ corrupt_mask[mem_address];
         mem[mem_address] = word;
         writes_seen++;
      end
      if (mem_read && !mem_waitrequest) begin
         idx = reads_issued;
         if (writes_seen != exp_addr.size()) begin
            stop_with_failure("a read was issued before the last write was accepted");
         end
         if (idx >= exp_addr.size()) stop_with_failure("more reads than the configured beats");
         check_addr("mem_address", mem_address, exp_addr[idx]);
         ret_data.push_back(mem.exists(mem_address) ? mem[mem_address] : fill_word(mem_address));
         ret_due.push_back(cycle + 2 + longint'(rand_state[6:4]));   // two to nine cycles.
         reads_issued++;
         if (reads_issued - reads_returned > `TG_MAX_OUTSTANDING) begin
            stop_with_failure("more reads in flight than the outstanding limit");
         end
      end
      if (mem_readdatavalid) reads_returned++;
   endtask

   always @(posedge clk) begin : memory_model
      logic in_reset;
      in_reset = reset;
      if (in_reset) begin
         clear_model();
      end else begin
         observe_bus();
      end
      cycle = cycle + 1;
      #1;
      rand_state      = xorshift32(rand_state);
      mem_waitrequest = (rand_state[1:0] == 2'b00);   // stalls about one cycle in four.
      if (!in_reset && ret_due.size() > 0 && ret_due[0] <= cycle) begin
         mem_readdatavalid = 1'b1;
         mem_readdata      = ret_data.pop_front();
         void'(ret_due.pop_front());
      end else begin
         mem_readdatavalid = 1'b0;
         mem_readdata      = '0;
      end
   end

   // ==============================
   // session runner
   // ==============================
   task automatic run_session(input int number, input logic exp_pass,
                              input logic [15:0] exp_errors, input tg_mem_addr_t exp_first);
      int               cycles;
      tg_engine_state_t eng_state;
      if (exp_addr.size() == 0) stop_with_failure("a trace session holds no write beats");
      check_count("trace beat count", 16'(exp_addr.size()), 16'(configured_value(`TG_REG_BEATS)));
      check_addr("trace first address", exp_addr[0],
                 tg_mem_addr_t'(configured_value(`TG_REG_BASE)));
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      check_flag("mem_write", mem_write, 1'b0);   // control outputs idle right after reset.
      check_flag("mem_read", mem_read, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("pass", pass, 1'b0);
      check_flag("fail", fail, 1'b0);
      cycles = 0;
      while (done !== 1'b1) begin
         if (cycles >= DONE_TIMEOUT) begin
            eng_state = UUT.u_engine.state;
            stop_with_failure($sformatf("timeout after %0d cycles waiting for done, engine in %s",
                                        cycles, eng_state.name()));
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      check_flag("pass", pass, exp_pass);
      check_flag("fail", fail, !exp_pass);
      check_count("error_count", error_count, exp_errors);
      if (!exp_pass) check_addr("first_fail_address", first_fail_address, exp_first);
      check_count("accepted writes", 16'(writes_seen), 16'(exp_addr.size()));
      check_count("accepted reads", 16'(reads_issued), 16'(exp_addr.size()));
      check_count("returned reads", 16'(reads_returned), 16'(exp_addr.size()));
      $display("session %0d finished after %0d cycles with %0d errors", number, cycles, error_count);
   endtask

   initial begin : run_trace
      int           fd;
      int           code;
      int           sessions;
      string        tok;
      string        rest;
      tg_mem_addr_t a;
      tg_mem_data_t d;
      logic         exp_pass;
      logic [15:0]  exp_errors;
      tg_mem_addr_t exp_first;
      reset             = 1'b1;
      mem_waitrequest   = 1'b0;
      mem_readdata      = '0;
      mem_readdatavalid = 1'b0;
      cycle             = 0;
      rand_state        = 32'h2935_5827;
      sessions          = 0;
      fd = $fopen("tg_trace.txt", "r");
      if (fd == 0) stop_with_failure("could not open the trace file tg_trace.txt");
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok.substr(0, 0) == "#") begin
            code = $fgets(rest, fd);   // rest of a comment line.
         end else if (tok == "S") begin
            exp_addr.delete();
            exp_data.delete();
            corrupt_mask.delete();
         end else if (tok == "W") begin
            code = $fscanf(fd, "%h %h", a, d);
            if (code != 2) stop_with_failure("a write beat in the trace is malformed");
            exp_addr.push_back(a);
            exp_data.push_back(d);
         end else if (tok == "C") begin
            code = $fscanf(fd, "%h %h", a, d);
            if (code != 2) stop_with_failure("a corruption entry in the trace is malformed");
            corrupt_mask[a] = corrupt_mask.exists(a) ? (corrupt_mask[a] ^ d) : d;
         end else if (tok == "E") begin
            code = $fscanf(fd, "%h %h %h", exp_pass, exp_errors, exp_first);
            if (code != 3) stop_with_failure("an expected result in the trace is malformed");
            sessions++;
            run_session(sessions, exp_pass, exp_errors, exp_first);
         end else begin
            stop_with_failure({"unknown keyword in the trace: ", tok});
         end
      end
      $fclose(fd);
      if (sessions == 0) begin
         stop_with_failure("the trace file holds no complete session");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- tg_subsys_top.sv
/*
 * Traffic generator subsystem.
 * Configuration master, register block and traffic engine; the memory bus
 * and the run results leave the top level.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tg_consts.svh"

module tg_subsys_top import tg_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   output logic         mem_write,
   output logic         mem_read,
   output tg_mem_addr_t mem_address,
   output tg_mem_data_t mem_writedata,
   input  logic         mem_waitrequest,
   input  tg_mem_data_t mem_readdata,
   input  logic         mem_readdatavalid,
   output logic         done,
   output logic         pass,
   output logic         fail,
   output logic [15:0]  error_count,
   output tg_mem_addr_t first_fail_address
);

   // ==============================
   // configuration bus
   // ==============================
   logic                          cfg_write;
   logic [`TG_CFG_ADDR_WIDTH-1:0] cfg_address;
   logic [`TG_CFG_DATA_WIDTH-1:0] cfg_writedata;
   logic                          cfg_waitrequest;
   logic                          at_wait_user_stage;

   // settings handed to the engine.
   logic                          start;
   tg_mem_addr_t                  base_address;
   tg_mem_addr_t                  beat_count;
   tg_mem_data_t                  seed;

   tg_cfg_master u_cfg_master (
      .clk                (clk),
      .reset              (reset),
      .at_wait_user_stage (at_wait_user_stage),
      .cfg_waitrequest    (cfg_waitrequest),
      .cfg_write          (cfg_write),
      .cfg_address        (cfg_address),
      .cfg_writedata      (cfg_writedata)
   );

   tg_cfg_regs u_cfg_regs (
      .clk                (clk),
      .reset              (reset),
      .cfg_write          (cfg_write),
      .cfg_address        (cfg_address),
      .cfg_writedata      (cfg_writedata),
      .cfg_waitrequest    (cfg_waitrequest),
      .at_wait_user_stage (at_wait_user_stage),
      .start              (start),
      .base_address       (base_address),
      .beat_count         (beat_count),
      .seed               (seed)
   );

   tg_traffic_engine u_engine (
      .clk                (clk),
      .reset              (reset),
      .start              (start),
      .base_address       (base_address),
      .beat_count         (beat_count),
      .seed               (seed),
      .mem_write          (mem_write),
      .mem_read           (mem_read),
      .mem_address        (mem_address),
      .mem_writedata      (mem_writedata),
      .mem_waitrequest    (mem_waitrequest),
      .mem_readdata       (mem_readdata),
      .mem_readdatavalid  (mem_readdatavalid),
      .done               (done),
      .pass               (pass),
      .fail               (fail),
      .error_count        (error_count),
      .first_fail_address (first_fail_address)
   );

endmodule

`default_nettype wire

//--- tg_traffic_engine.sv
/*
 * Traffic engine.
 * Writes an LFSR pattern to memory, reads it back with several reads in
 * flight and checks every returned beat against a second LFSR copy.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tg_consts.svh"

module tg_traffic_engine import tg_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         start,
   input  tg_mem_addr_t base_address,
   input  tg_mem_addr_t beat_count,
   input  tg_mem_data_t seed,
   output logic         mem_write,
   output logic         mem_read,
   output tg_mem_addr_t mem_address,
   output tg_mem_data_t mem_writedata,
   input  logic         mem_waitrequest,
   input  tg_mem_data_t mem_readdata,
   input  logic         mem_readdatavalid,
   output logic         done,
   output logic         pass,
   output logic         fail,
   output logic [15:0]  error_count,
   output tg_mem_addr_t first_fail_address
);

   localparam int OUTST_W = $clog2(`TG_MAX_OUTSTANDING + 1);

   tg_engine_state_t   state;
   tg_mem_addr_t       wr_idx;
   tg_mem_addr_t       rd_idx;
   tg_mem_addr_t       ret_idx;
   tg_mem_addr_t       last_idx;
   logic [OUTST_W-1:0] outstanding;
   tg_mem_data_t       wr_pattern;
   tg_mem_data_t       chk_pattern;
   logic               start_run;
   logic               wr_accept;
   logic               rd_accept;
   logic               mismatch;

   assign start_run = start && (state == ENG_IDLE);
   assign last_idx  = beat_count - 1'b1;

   tg_pattern_gen u_wr_gen (
      .clk     (clk),
      .reset   (reset),
      .load    (start_run),
      .seed    (seed),
      .advance (wr_accept),
      .pattern (wr_pattern)
   );

   tg_pattern_gen u_chk_gen (
      .clk     (clk),
      .reset   (reset),
      .load    (start_run),
      .seed    (seed),
      .advance (mem_readdatavalid),
      .pattern (chk_pattern)
   );

   // ==============================
   // memory command path
   // ==============================
   // a read stays up until accepted, the outstanding count only rises on accept.
   assign mem_write     = (state == ENG_WRITE);
   assign mem_read      = (state == ENG_READ) && (outstanding < `TG_MAX_OUTSTANDING);
   assign mem_address   = base_address + (mem_write ? wr_idx : rd_idx);
   assign mem_writedata = wr_pattern;
   assign wr_accept     = mem_write && !mem_waitrequest;
   assign rd_accept     = mem_read && !mem_waitrequest;
   assign mismatch      = mem_readdatavalid && (mem_readdata != chk_pattern);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ENG_IDLE;
      end else begin
         case (state)
            ENG_IDLE:  if (start) state <= (beat_count == '0) ? ENG_DONE : ENG_WRITE;
            ENG_WRITE: if (wr_accept && wr_idx == last_idx) state <= ENG_READ;
            ENG_READ:  if (rd_accept && rd_idx == last_idx) state <= ENG_DRAIN;
            ENG_DRAIN: if (mem_readdatavalid && ret_idx == last_idx) state <= ENG_DONE;
            ENG_DONE:  state <= ENG_DONE;
            default:   state <= ENG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset || start_run) begin
         wr_idx  <= '0;
         rd_idx  <= '0;
         ret_idx <= '0;
      end else begin
         if (wr_accept) wr_idx <= wr_idx + 1'b1;
         if (rd_accept) rd_idx <= rd_idx + 1'b1;
         if (mem_readdatavalid) ret_idx <= ret_idx + 1'b1;   // beats return in order.
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         outstanding <= '0;
      end else begin
         outstanding <= outstanding + OUTST_W'(rd_accept) - OUTST_W'(mem_readdatavalid);
      end
   end

   // ==============================
   // result tracking
   // ==============================
   always_ff @(posedge clk) begin
      if (reset || start_run) begin
         error_count        <= '0;
         first_fail_address <= '0;
      end else if (mismatch) begin
         error_count <= error_count + 1'b1;
         if (error_count == '0) begin
            first_fail_address <= base_address + ret_idx;
         end
      end
   end

   assign done = (state == ENG_DONE);
   assign pass = done && (error_count == '0);
   assign fail = done && (error_count != '0);

endmodule

`default_nettype wire

//--- tg_cfg_regs.sv
/*
 * Configuration register slave.
 * Holds base address, beat count and seed, inserts one wait state per
 * write, and launches the engine when START is written.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tg_consts.svh"

module tg_cfg_regs import tg_pkg::*; (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          cfg_write,
   input  logic [`TG_CFG_ADDR_WIDTH-1:0] cfg_address,
   input  logic [`TG_CFG_DATA_WIDTH-1:0] cfg_writedata,
   output logic                          cfg_waitrequest,
   output logic                          at_wait_user_stage,
   output logic                          start,
   output tg_mem_addr_t                  base_address,
   output tg_mem_addr_t                  beat_count,
   output tg_mem_data_t                  seed
);

   logic wait_done;
   logic accept;
   logic start_hit;
   logic waiting;

   // ==============================
   // wait state generation
   // ==============================
   // first cycle of a write stalls, the second one is accepted.
   assign cfg_waitrequest = cfg_write && !wait_done;
   assign accept          = cfg_write && !cfg_waitrequest;
   assign start_hit       = accept && (cfg_address == `TG_REG_START);

   always_ff @(posedge clk) begin
      if (reset) begin
         wait_done <= 1'b0;
      end else begin
         wait_done <= cfg_waitrequest;   // set after the stall cycle, cleared on accept.
      end
   end

   // ==============================
   // control
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         waiting <= 1'b1;   // ask for user settings as soon as reset is released.
         start   <= 1'b0;
      end else begin
         start <= start_hit;
         if (start_hit) begin
            waiting <= 1'b0;
         end
      end
   end

   assign at_wait_user_stage = waiting;

   // settings registers, unknown addresses are simply dropped.
   always_ff @(posedge clk) begin
      if (accept) begin
         case (cfg_address)
            `TG_REG_BASE:  base_address <= cfg_writedata[`TG_MEM_ADDR_WIDTH-1:0];
            `TG_REG_BEATS: beat_count   <= cfg_writedata[`TG_MEM_ADDR_WIDTH-1:0];
            `TG_REG_SEED:  seed         <= cfg_writedata;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- tg_cfg_master.sv
/*
 * Configuration master.
 * Waits for the register block to ask for user settings, then writes the
 * user table row by row over the configuration bus, START last.
 */

`timescale 1ns/1ps
`default_nettype none

`include "tg_consts.svh"

module tg_cfg_master import tg_pkg::*; (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          at_wait_user_stage,
   input  logic                          cfg_waitrequest,
   output logic                          cfg_write,
   output logic [`TG_CFG_ADDR_WIDTH-1:0] cfg_address,
   output logic [`TG_CFG_DATA_WIDTH-1:0] cfg_writedata
);

   localparam int ROW_W = (TG_USER_CFG_N_ROW > 1) ? $clog2(TG_USER_CFG_N_ROW) : 1;
   localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(TG_USER_CFG_N_ROW - 1);

   typedef enum logic [1:0] {
      MST_INIT,
      MST_WRITE_USER_TRAFFIC,
      MST_DONE
   } mst_state_t;

   mst_state_t       state;
   logic [ROW_W-1:0] row;
   logic             accept;

   assign accept = cfg_write && !cfg_waitrequest;

   // ==============================
   // row sequencing
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= MST_INIT;
         row   <= '0;
      end else begin
         case (state)
            MST_INIT: begin
               row <= '0;
               if (at_wait_user_stage) begin
                  state <= MST_WRITE_USER_TRAFFIC;
               end
            end
            MST_WRITE_USER_TRAFFIC: begin
               if (accept) begin
                  if (row == LAST_ROW) begin
                     state <= MST_DONE;   // nothing more is sent after START.
                  end else begin
                     row <= row + 1'b1;
                  end
               end
            end
            MST_DONE: state <= MST_DONE;
            default:  state <= MST_INIT;
         endcase
      end
   end

   // the row only moves on acceptance, so address and data hold during a stall.
   assign cfg_write     = (state == MST_WRITE_USER_TRAFFIC);
   assign cfg_address   = TG_USER_CFG_ROWS[row].addr;
   assign cfg_writedata = TG_USER_CFG_ROWS[row].data;

endmodule

`default_nettype wire

//--- tg_pattern_gen.sv
/*
 * LFSR data pattern generator.
 * 32-bit Galois LFSR, loaded from a seed and stepped once per beat.
 */

`timescale 1ns/1ps
`default_nettype none

module tg_pattern_gen import tg_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         load,
   input  tg_mem_data_t seed,
   input  logic         advance,
   output tg_mem_data_t pattern
);

   // x^32 + x^22 + x^2 + x + 1, maximal length.
   localparam tg_mem_data_t TAPS      = 32'h8020_0003;
   localparam tg_mem_data_t ZERO_SEED = 32'hB5AD_4ECE;   // used in place of an all zero seed.

   tg_mem_data_t lfsr;

   always_ff @(posedge clk) begin
      if (reset) begin
         lfsr <= ZERO_SEED;
      end else if (load) begin
         lfsr <= (seed == '0) ? ZERO_SEED : seed;   // zero would lock the register up.
      end else if (advance) begin
         lfsr <= (lfsr >> 1) ^ ({32{lfsr[0]}} & TAPS);
      end
   end

   assign pattern = lfsr;

endmodule

`default_nettype wire

//--- tg_pkg.sv
/*
 * Traffic generator package.
 * Memory bus types, engine states and the user configuration table that
 * the configuration master replays after reset.
 */

`default_nettype none

`include "tg_consts.svh"

package tg_pkg;

   typedef logic [`TG_MEM_ADDR_WIDTH-1:0] tg_mem_addr_t;
   typedef logic [`TG_MEM_DATA_WIDTH-1:0] tg_mem_data_t;

   typedef enum logic [2:0] {
      ENG_IDLE,
      ENG_WRITE,
      ENG_READ,
      ENG_DRAIN,
      ENG_DONE
   } tg_engine_state_t;

   typedef struct packed {
      logic [`TG_CFG_ADDR_WIDTH-1:0] addr;
      logic [`TG_CFG_DATA_WIDTH-1:0] data;
   } tg_cfg_row_t;

   // ==============================
   // user configuration table
   // ==============================
   localparam int TG_USER_CFG_N_ROW = 4;

   // START must stay the last row, it launches the engine.
   localparam tg_cfg_row_t TG_USER_CFG_ROWS [TG_USER_CFG_N_ROW] = '{
      '{addr: `TG_REG_BASE,  data: 32'h0000_0100},
      '{addr: `TG_REG_BEATS, data: 32'h0000_0010},
      '{addr: `TG_REG_SEED,  data: 32'h1D87_2B41},
      '{addr: `TG_REG_START, data: 32'h0000_0001}
   };

endpackage

`default_nettype wire

//--- tg_consts.svh
/*
 * Traffic generator constants.
 * Bus widths, the configuration register map and the read pipelining limit.
 */

`ifndef TG_CONSTS_SVH
`define TG_CONSTS_SVH

// ==============================
// bus widths
// ==============================
`define TG_CFG_ADDR_WIDTH 4
`define TG_CFG_DATA_WIDTH 32
`define TG_MEM_ADDR_WIDTH 16
`define TG_MEM_DATA_WIDTH 32

// ==============================
// configuration register map
// ==============================
`define TG_REG_BASE  4'd0
`define TG_REG_BEATS 4'd1
`define TG_REG_SEED  4'd2
`define TG_REG_START 4'd3

`define TG_MAX_OUTSTANDING 4

`endif
